//--- hdl/conv_store_macros.svh
`ifndef CONV_STORE_MACROS_SVH
`define CONV_STORE_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// fifo grid of the systolic array output
//////////////////////////////////////////////////////////////////////
// channel groups per output row
`define SA_ROW_NUM 4
// output rows per tile
`define SA_COLUMN_NUM 3
`define FIFO_NUM (`SA_ROW_NUM * `SA_COLUMN_NUM)
// channels per fifo in int8 mode, doubled in wide mode
`define ROW_CH_NUM 16

//////////////////////////////////////////////////////////////////////
// word widths and ddr limits
//////////////////////////////////////////////////////////////////////
`define SLICE_WIDTH 256
`define DDR_WORD_WIDTH 512
`define CMD_WORD_MAX 32
// log2 of pixels per ddr row stride
`define PIXELS_ROW_2POW 5
`define ADR_WIDTH 32
`define IDX_WIDTH 16

`endif

//--- hdl/conv_store_pkg.sv
`default_nettype none
`include "conv_store_macros.svh"

package conv_store_pkg;

  typedef enum logic {mode_int8, mode_wide} store_mode_e;

  // command window of the store side
  typedef enum logic {idle, open} window_state_e;

  // tile description, start fields are one-based
  typedef struct packed {
    logic [`ADR_WIDTH-1:0] layer_base_adr;
    store_mode_e           mode;
    logic [3:0]            of_2pow;
    logic [3:0]            ox_2pow;
    logic [`IDX_WIDTH-1:0] of_start;
    logic [`IDX_WIDTH-1:0] oy_start;
    logic [`IDX_WIDTH-1:0] ox_start;
    logic [`IDX_WIDTH-1:0] pof;
    logic [`IDX_WIDTH-1:0] poy;
  } tile_cfg_t;

  typedef struct packed {
    logic [`ADR_WIDTH-1:0] base_adr;
    logic [`IDX_WIDTH-1:0] length;
  } store_cmd_t;

  typedef struct packed {
    logic [`ADR_WIDTH-1:0]      adr;
    logic [`DDR_WORD_WIDTH-1:0] data;
  } ddr_beat_t;

  // ddr word address of the channel pair at row and channel offset
  function automatic logic [`ADR_WIDTH-1:0] word_adr(input tile_cfg_t cfg,
                                                     input logic [`IDX_WIDTH-1:0] row,
                                                     input logic [`IDX_WIDTH-1:0] ch);
    logic [`ADR_WIDTH-1:0] row_abs;
    logic [`ADR_WIDTH-1:0] x_abs;
    logic [`ADR_WIDTH-1:0] ch_abs;
    logic [5:0]            row_sh;
    logic [5:0]            x_sh;
    row_abs = `ADR_WIDTH'(cfg.oy_start) + `ADR_WIDTH'(row) - 1;
    x_abs   = `ADR_WIDTH'(cfg.ox_start) - 1;
    ch_abs  = `ADR_WIDTH'(cfg.of_start) + `ADR_WIDTH'(ch) - 1;
    row_sh  = 6'(cfg.of_2pow) + 6'(cfg.ox_2pow) - 6'd1 - 6'(`PIXELS_ROW_2POW);
    x_sh    = 6'(cfg.of_2pow) - 6'd1;
    return cfg.layer_base_adr + (row_abs << row_sh) +
           ((x_abs << x_sh) >> `PIXELS_ROW_2POW) + (ch_abs >> 1);
  endfunction

endpackage

`default_nettype wire

//--- hdl/store_cmd_gen.sv
`timescale 1ns/1ps
`default_nettype none
`include "conv_store_macros.svh"

module store_cmd_gen (
  input  wire                        clk,
  input  wire                        reset,
  input  wire                        store_start,
  input  wire conv_store_pkg::tile_cfg_t tile_cfg,
  input  wire                        ddr_cmd_ready,
  input  wire                        window_done,
  output conv_store_pkg::store_cmd_t store_cmd,
  output logic                       store_cmd_valid,
  output logic                       window_open,
  output logic [`IDX_WIDTH-1:0]      window_len
);
  import conv_store_pkg::*;

  logic                  active;
  window_state_e         state;
  logic [`IDX_WIDTH-1:0] cmd_row;
  logic [`IDX_WIDTH-1:0] cmd_ch;
  logic [`IDX_WIDTH-1:0] words_left;
  logic [`IDX_WIDTH-1:0] cmd_len;
  logic                  row_done;
  logic                  tile_done;

  //////////////////////////////////////////////////////////////////////
  // command fields for the current row and channel run
  //////////////////////////////////////////////////////////////////////
  // two channels per word
  assign words_left = (tile_cfg.pof - cmd_ch) >> 1;
  assign cmd_len    = (words_left > `CMD_WORD_MAX) ? `IDX_WIDTH'(`CMD_WORD_MAX) : words_left;
  assign row_done   = (cmd_ch + (cmd_len << 1)) >= tile_cfg.pof;
  assign tile_done  = row_done && (cmd_row == tile_cfg.poy - 1'b1);

  assign store_cmd_valid    = active && (state == idle) && ddr_cmd_ready;
  assign store_cmd.base_adr = word_adr(tile_cfg, cmd_row, cmd_ch);
  assign store_cmd.length   = cmd_len;
  assign window_open        = (state == open);

  // row and run walk
  always_ff @(posedge clk) begin
    if (reset) begin
      active  <= 1'b0;
      cmd_row <= '0;
      cmd_ch  <= '0;
    end else if (store_start) begin
      active  <= 1'b1;
      cmd_row <= '0;
      cmd_ch  <= '0;
    end else if (store_cmd_valid) begin
      if (tile_done) begin
        active <= 1'b0;
      end
      if (row_done) begin
        cmd_ch  <= '0;
        cmd_row <= tile_done ? '0 : cmd_row + 1'b1;
      end else begin
        cmd_ch <= cmd_ch + (cmd_len << 1);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // window fsm
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= idle;
      window_len <= '0;
    end else begin
      case (state)
        idle: begin
          if (store_cmd_valid) begin
            state      <= open;
            window_len <= cmd_len;
          end
        end
        open: begin
          // closed once the last beat has left
          if (window_done) begin
            state <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hdl/fifo_drain_seq.sv
`timescale 1ns/1ps
`default_nettype none
`include "conv_store_macros.svh"

module fifo_drain_seq (
  input  wire                        clk,
  input  wire                        reset,
  input  wire conv_store_pkg::tile_cfg_t tile_cfg,
  input  wire                        read_allow,
  output logic [`FIFO_NUM-1:0]       fifo_rds,
  output logic [`ADR_WIDTH-1:0]      read_adr,
  output logic                       read_half,
  output logic                       tile_last
);
  import conv_store_pkg::*;

  localparam int CH_SHIFT = $clog2(`ROW_CH_NUM);
  localparam int SEL_W    = $clog2(`FIFO_NUM);

  logic [`IDX_WIDTH-1:0] rd_row;
  logic [`IDX_WIDTH-1:0] rd_ch;
  logic [`IDX_WIDTH-1:0] ch_step;
  logic [`IDX_WIDTH-1:0] ch_group;
  logic [SEL_W-1:0]      fifo_sel;
  logic                  wide;
  logic                  row_end;
  logic                  last_row;

  assign wide = (tile_cfg.mode == mode_wide);

  //////////////////////////////////////////////////////////////////////
  // read position decode
  //////////////////////////////////////////////////////////////////////
  // one slice per read in int8, a full channel pair in wide mode
  assign ch_step  = wide ? `IDX_WIDTH'(2) : `IDX_WIDTH'(1);
  assign row_end  = (rd_ch + ch_step) >= tile_cfg.pof;
  assign last_row = (rd_row == tile_cfg.poy - 1'b1);

  // a wide fifo holds twice the channels
  assign ch_group = wide ? (rd_ch >> (CH_SHIFT + 1)) : (rd_ch >> CH_SHIFT);
  assign fifo_sel = SEL_W'(rd_row * `SA_ROW_NUM + ch_group);

  always_comb begin
    fifo_rds = '0;
    if (read_allow) begin
      fifo_rds[fifo_sel] = 1'b1;
    end
  end

  // beat address, shared by both halves of a pair
  assign read_adr  = word_adr(tile_cfg, rd_row, rd_ch);
  // odd channel closes an int8 pair
  assign read_half = !wide && rd_ch[0];
  assign tile_last = read_allow && row_end && last_row;

  //////////////////////////////////////////////////////////////////////
  // channel and row counters of the read side
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_row <= '0;
      rd_ch  <= '0;
    end else if (read_allow) begin
      if (row_end) begin
        rd_ch <= '0;
        // wrap back for the next tile
        if (last_row) begin
          rd_row <= '0;
        end else begin
          rd_row <= rd_row + 1'b1;
        end
      end else begin
        rd_ch <= rd_ch + ch_step;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/ddr_beat_assembler.sv
`timescale 1ns/1ps
`default_nettype none
`include "conv_store_macros.svh"

module ddr_beat_assembler (
  input  wire                        clk,
  input  wire                        reset,
  input  wire conv_store_pkg::tile_cfg_t tile_cfg,
  input  wire                        window_open,
  input  wire [`IDX_WIDTH-1:0]       window_len,
  input  wire                        ddr_data_ready,
  input  wire [`ADR_WIDTH-1:0]       read_adr,
  input  wire                        read_half,
  input  wire                        tile_last,
  input  wire [`DDR_WORD_WIDTH-1:0]  fifo_data,
  output logic                       read_allow,
  output logic                       window_done,
  output conv_store_pkg::ddr_beat_t  ddr_beat,
  output logic                       ddr_beat_valid,
  output logic                       store_fin
);
  import conv_store_pkg::*;

  logic                     wide;
  logic [`IDX_WIDTH:0]      read_budget;
  logic [`IDX_WIDTH:0]      read_cnt;
  logic [`IDX_WIDTH-1:0]    beat_cnt;
  logic                     data_valid;
  logic [`ADR_WIDTH-1:0]    data_adr;
  logic                     data_half;
  logic                     data_last;
  logic                     beat_last;
  logic                     beat_ready;
  logic [`SLICE_WIDTH-1:0]  low_slice;

  assign wide = (tile_cfg.mode == mode_wide);

  //////////////////////////////////////////////////////////////////////
  // read budget of the open window
  //////////////////////////////////////////////////////////////////////
  // two slice reads per word in int8
  assign read_budget = wide ? {1'b0, window_len} : {window_len, 1'b0};
  assign read_allow  = window_open && ddr_data_ready && (read_cnt < read_budget);

  always_ff @(posedge clk) begin
    if (reset) begin
      read_cnt <= '0;
    end else if (!window_open) begin
      read_cnt <= '0;
    end else if (read_allow) begin
      read_cnt <= read_cnt + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // beat packing
  //////////////////////////////////////////////////////////////////////
  // fifo data completes a beat
  assign beat_ready = data_valid && (wide || data_half);

  always_ff @(posedge clk) begin
    if (reset) begin
      data_valid     <= 1'b0;
      data_last      <= 1'b0;
      beat_last      <= 1'b0;
      ddr_beat_valid <= 1'b0;
      store_fin      <= 1'b0;
    end else begin
      data_valid     <= read_allow;
      data_last      <= tile_last;
      beat_last      <= data_last;
      ddr_beat_valid <= beat_ready;
      store_fin      <= beat_last;
    end
  end

  // tags line up with fifo_data one cycle after the strobe
  always_ff @(posedge clk) begin
    data_adr  <= read_adr;
    data_half <= read_half;
    if (data_valid && !data_half) begin
      low_slice <= fifo_data[`SLICE_WIDTH-1:0];
    end
    if (beat_ready) begin
      ddr_beat.adr  <= data_adr;
      ddr_beat.data <= wide ? fifo_data : {fifo_data[`SLICE_WIDTH-1:0], low_slice};
    end
  end

  // beats per window
  assign window_done = ddr_beat_valid && (beat_cnt == window_len - 1'b1);

  always_ff @(posedge clk) begin
    if (reset) begin
      beat_cnt <= '0;
    end else if (window_done) begin
      beat_cnt <= '0;
    end else if (ddr_beat_valid) begin
      beat_cnt <= beat_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- hdl/conv_store_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "conv_store_macros.svh"

module conv_store_top (
  input  wire                        clk,
  input  wire                        reset,
  input  wire                        store_start,
  input  wire conv_store_pkg::tile_cfg_t tile_cfg,
  input  wire                        ddr_cmd_ready,
  input  wire                        ddr_data_ready,
  input  wire [`DDR_WORD_WIDTH-1:0]  fifo_data,
  output logic [`FIFO_NUM-1:0]       fifo_rds,
  output conv_store_pkg::store_cmd_t store_cmd,
  output logic                       store_cmd_valid,
  output conv_store_pkg::ddr_beat_t  ddr_beat,
  output logic                       ddr_beat_valid,
  output logic                       store_fin
);

  // window handshake between command and data side
  logic                  window_open;
  logic [`IDX_WIDTH-1:0] window_len;
  logic                  window_done;
  logic                  read_allow;

  // read tags from the drain side
  logic [`ADR_WIDTH-1:0] read_adr;
  logic                  read_half;
  logic                  tile_last;

  store_cmd_gen cmd_gen_i (
    .clk             (clk),
    .reset           (reset),
    .store_start     (store_start),
    .tile_cfg        (tile_cfg),
    .ddr_cmd_ready   (ddr_cmd_ready),
    .window_done     (window_done),
    .store_cmd       (store_cmd),
    .store_cmd_valid (store_cmd_valid),
    .window_open     (window_open),
    .window_len      (window_len)
  );

  fifo_drain_seq drain_seq_i (
    .clk        (clk),
    .reset      (reset),
    .tile_cfg   (tile_cfg),
    .read_allow (read_allow),
    .fifo_rds   (fifo_rds),
    .read_adr   (read_adr),
    .read_half  (read_half),
    .tile_last  (tile_last)
  );

  ddr_beat_assembler beat_asm_i (
    .clk            (clk),
    .reset          (reset),
    .tile_cfg       (tile_cfg),
    .window_open    (window_open),
    .window_len     (window_len),
    .ddr_data_ready (ddr_data_ready),
    .read_adr       (read_adr),
    .read_half      (read_half),
    .tile_last      (tile_last),
    .fifo_data      (fifo_data),
    .read_allow     (read_allow),
    .window_done    (window_done),
    .ddr_beat       (ddr_beat),
    .ddr_beat_valid (ddr_beat_valid),
    .store_fin      (store_fin)
  );

endmodule

`default_nettype wire

//--- verification/conv_store_checker.sv
`timescale 1ns/1ps
`default_nettype none
`include "conv_store_macros.svh"

module conv_store_checker (
  input wire                             clk,
  input wire                             reset,
  input wire                             store_start,
  input wire conv_store_pkg::tile_cfg_t  tile_cfg,
  input wire                             ddr_cmd_ready,
  input wire                             ddr_data_ready,
  input wire [`FIFO_NUM-1:0]             fifo_rds,
  input wire conv_store_pkg::store_cmd_t store_cmd,
  input wire                             store_cmd_valid,
  input wire conv_store_pkg::ddr_beat_t  ddr_beat,
  input wire                             ddr_beat_valid,
  input wire                             store_fin
);
  import conv_store_pkg::*;

  int         error_count;
  store_cmd_t exp_cmds [$];
  ddr_beat_t  exp_beats [$];
  int         beats_left;
  logic       tile_open;
  // final beat of the tile left in the previous cycle
  logic       last_beat_prev;
  logic       reset_prev;

  initial begin
    error_count    = 0;
    beats_left     = 0;
    tile_open      = 1'b0;
    last_beat_prev = 1'b0;
    reset_prev     = 1'b0;
  end

  task automatic report_error(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    error_count++;
  endtask

  // one-based start fields against zero-based row and channel
  function automatic logic [`ADR_WIDTH-1:0] expected_adr(input tile_cfg_t cfg, input int row,
                                                         input int ch);
    int unsigned row_abs;
    int unsigned x_abs;
    int unsigned ch_abs;
    row_abs = cfg.oy_start - 1 + row;
    x_abs   = cfg.ox_start - 1;
    ch_abs  = cfg.of_start - 1 + ch;
    return cfg.layer_base_adr
         + (row_abs << (cfg.of_2pow + cfg.ox_2pow - 1 - `PIXELS_ROW_2POW))
         + ((x_abs << (cfg.of_2pow - 1)) >> `PIXELS_ROW_2POW)
         + (ch_abs >> 1);
  endfunction

  // data a fifo returns on its n-th read of the tile
  function automatic logic [`DDR_WORD_WIDTH-1:0] slice_data(input int fifo, input int count,
                                                           input logic wide);
    logic [`DDR_WORD_WIDTH-1:0] word;
    word = '0;
    for (int k = 0; k < `DDR_WORD_WIDTH / 32; k++) begin
      if (wide || k < `SLICE_WIDTH / 32) begin
        word[k*32 +: 32] = {8'(fifo), 8'(k), 16'(count)};
      end
    end
    return word;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // reference model of one tile
  //////////////////////////////////////////////////////////////////////
  function automatic void build_reference(input tile_cfg_t cfg);
    int                         reads [`FIFO_NUM];
    int                         fifo_ch;
    int                         len;
    int                         ch;
    int                         f;
    logic                       wide;
    logic [`DDR_WORD_WIDTH-1:0] data;
    logic [`DDR_WORD_WIDTH-1:0] hi;
    store_cmd_t                 cmd;
    ddr_beat_t                  beat;
    exp_cmds.delete();
    exp_beats.delete();
    foreach (reads[i]) begin
      reads[i] = 0;
    end
    wide    = (cfg.mode == mode_wide);
    fifo_ch = wide ? 2 * `ROW_CH_NUM : `ROW_CH_NUM;
    for (int row = 0; row < int'(cfg.poy); row++) begin
      ch = 0;
      while (ch < int'(cfg.pof)) begin
        len = (int'(cfg.pof) - ch) / 2;
        if (len > `CMD_WORD_MAX) begin
          len = `CMD_WORD_MAX;
        end
        cmd.base_adr = expected_adr(cfg, row, ch);
        cmd.length   = 16'(len);
        exp_cmds.push_back(cmd);
        for (int w = 0; w < len; w++) begin
          f        = row * `SA_ROW_NUM + (ch + 2 * w) / fifo_ch;
          data     = slice_data(f, reads[f], wide);
          reads[f] = reads[f] + 1;
          // odd channel slice goes to the upper half in int8
          if (!wide) begin
            f        = row * `SA_ROW_NUM + (ch + 2 * w + 1) / fifo_ch;
            hi       = slice_data(f, reads[f], 1'b0);
            reads[f] = reads[f] + 1;
            data     = {hi[`SLICE_WIDTH-1:0], data[`SLICE_WIDTH-1:0]};
          end
          beat.adr  = expected_adr(cfg, row, ch + 2 * w);
          beat.data = data;
          exp_beats.push_back(beat);
        end
        ch = ch + 2 * len;
      end
    end
  endfunction

  //////////////////////////////////////////////////////////////////////
  // comparison against the reference streams
  //////////////////////////////////////////////////////////////////////
  task automatic check_command();
    store_cmd_t exp_cmd;
    if (beats_left != 0 || ddr_beat_valid) begin
      report_error("command issued before the previous window completed");
    end
    if (exp_cmds.size() == 0) begin
      report_error("unexpected store command");
    end else begin
      exp_cmd = exp_cmds.pop_front();
      if (store_cmd !== exp_cmd) begin
        $display("ERROR at %0t: command adr 0x%08h len %0d, expected adr 0x%08h len %0d",
                 $time, store_cmd.base_adr, store_cmd.length, exp_cmd.base_adr,
                 exp_cmd.length);
        error_count++;
      end
      beats_left = int'(exp_cmd.length);
    end
  endtask

  task automatic check_beat();
    ddr_beat_t exp_beat;
    if (exp_beats.size() == 0) begin
      report_error("unexpected ddr beat");
    end else begin
      exp_beat = exp_beats.pop_front();
      if (ddr_beat !== exp_beat) begin
        $display("ERROR at %0t: beat adr 0x%08h, expected 0x%08h, data %s", $time,
                 ddr_beat.adr, exp_beat.adr,
                 (ddr_beat.data === exp_beat.data) ? "matches" : "differs");
        error_count++;
      end
      beats_left = beats_left - 1;
    end
  endtask

  task automatic check_fin();
    if (!tile_open) begin
      report_error("store_fin without an active tile");
    end else if (!last_beat_prev || exp_cmds.size() != 0 || exp_beats.size() != 0) begin
      report_error("store_fin not one cycle after the final beat of the tile");
    end
    tile_open = 1'b0;
  endtask

  always @(negedge clk) begin
    if (reset) begin
      if (reset_prev && (store_cmd_valid || ddr_beat_valid || store_fin || fifo_rds != '0)) begin
        report_error("DUT output active during reset");
      end
      exp_cmds.delete();
      exp_beats.delete();
      tile_open      = 1'b0;
      beats_left     = 0;
      last_beat_prev = 1'b0;
    end else begin
      if (store_start) begin
        build_reference(tile_cfg);
        tile_open  = 1'b1;
        beats_left = 0;
      end
      if (store_cmd_valid) begin
        check_command();
      end
      if (ddr_beat_valid) begin
        check_beat();
      end
      if (store_fin) begin
        check_fin();
      end
      last_beat_prev = ddr_beat_valid && tile_open && (exp_beats.size() == 0);
      if (store_cmd_valid && !ddr_cmd_ready) begin
        report_error("store command issued while ddr_cmd_ready is low");
      end
      if (fifo_rds != '0 && !ddr_data_ready) begin
        report_error("fifo read strobed while ddr_data_ready is low");
      end
      if ($countones(fifo_rds) > 1) begin
        report_error("more than one fifo strobed in a cycle");
      end
    end
    reset_prev = reset;
  end

endmodule

`default_nettype wire

//--- verification/conv_store_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "conv_store_macros.svh"

module conv_store_tb;
  import conv_store_pkg::*;

  localparam int TIMEOUT_CYCLES = 5000;

  logic                       clk;
  logic                       reset;
  logic                       store_start;
  tile_cfg_t                  tile_cfg;
  logic                       ddr_cmd_ready;
  logic                       ddr_data_ready;
  logic [`DDR_WORD_WIDTH-1:0] fifo_data;
  logic [`FIFO_NUM-1:0]       fifo_rds;
  store_cmd_t                 store_cmd;
  logic                       store_cmd_valid;
  ddr_beat_t                  ddr_beat;
  logic                       ddr_beat_valid;
  logic                       store_fin;

  // fifo model state
  logic [`FIFO_NUM-1:0]       rds_seen;
  int                         rd_count [`FIFO_NUM];
  // mode 0 keeps both ready levels high, 1 randomizes both and 2 only the command ready
  int                         ready_mode;
  int                         tb_errors;
  int                         tests_run;
  int                         tests_failed;

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  conv_store_top dut_i (
    .clk             (clk),
    .reset           (reset),
    .store_start     (store_start),
    .tile_cfg        (tile_cfg),
    .ddr_cmd_ready   (ddr_cmd_ready),
    .ddr_data_ready  (ddr_data_ready),
    .fifo_data       (fifo_data),
    .fifo_rds        (fifo_rds),
    .store_cmd       (store_cmd),
    .store_cmd_valid (store_cmd_valid),
    .ddr_beat        (ddr_beat),
    .ddr_beat_valid  (ddr_beat_valid),
    .store_fin       (store_fin)
  );

  conv_store_checker checker_i (
    .clk             (clk),
    .reset           (reset),
    .store_start     (store_start),
    .tile_cfg        (tile_cfg),
    .ddr_cmd_ready   (ddr_cmd_ready),
    .ddr_data_ready  (ddr_data_ready),
    .fifo_rds        (fifo_rds),
    .store_cmd       (store_cmd),
    .store_cmd_valid (store_cmd_valid),
    .ddr_beat        (ddr_beat),
    .ddr_beat_valid  (ddr_beat_valid),
    .store_fin       (store_fin)
  );

  // each 32-bit lane holds fifo number, lane index and that fifo's read count
  function automatic logic [`DDR_WORD_WIDTH-1:0] fifo_pattern(input int fifo, input int count,
                                                             input logic wide);
    logic [`DDR_WORD_WIDTH-1:0] word;
    word = '0;
    for (int k = 0; k < `DDR_WORD_WIDTH / 32; k++) begin
      if (wide || k < `SLICE_WIDTH / 32) begin
        word[k*32 +: 32] = {8'(fifo), 8'(k), 16'(count)};
      end
    end
    return word;
  endfunction

  function automatic tile_cfg_t make_cfg(input store_mode_e mode, input int pof, input int poy,
                                         input int oy_start, input int of_start);
    tile_cfg_t cfg;
    cfg.layer_base_adr = 32'h0010_0000;
    cfg.mode           = mode;
    cfg.of_2pow        = 4'd7;
    cfg.ox_2pow        = 4'd5;
    cfg.of_start       = 16'(of_start);
    cfg.oy_start       = 16'(oy_start);
    cfg.ox_start       = 16'd3;
    cfg.pof            = 16'(pof);
    cfg.poy            = 16'(poy);
    return cfg;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // fifo model and ddr ready levels
  //////////////////////////////////////////////////////////////////////
  // strobes of this cycle are answered after the next edge
  always @(negedge clk) begin
    if (store_start) begin
      foreach (rd_count[f]) begin
        rd_count[f] = 0;
      end
    end
    rds_seen = fifo_rds;
  end

  always @(posedge clk) begin
    #1;
    fifo_data = '0;
    for (int f = 0; f < `FIFO_NUM; f++) begin
      if (rds_seen[f]) begin
        fifo_data   = fifo_pattern(f, rd_count[f], tile_cfg.mode == mode_wide);
        rd_count[f] = rd_count[f] + 1;
      end
    end
    ddr_data_ready = (ready_mode == 1) ? 1'($urandom) : 1'b1;
    ddr_cmd_ready  = (ready_mode != 0) ? 1'($urandom) : 1'b1;
  end

  //////////////////////////////////////////////////////////////////////
  // test sequencing
  //////////////////////////////////////////////////////////////////////
  task automatic apply_reset();
    ready_mode = 0;
    @(posedge clk);
    #1;
    reset = 1'b1;
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;
  endtask

  task automatic start_tile(input tile_cfg_t cfg, input int mode);
    ready_mode = mode;
    @(posedge clk);
    #1;
    tile_cfg    = cfg;
    store_start = 1'b1;
    @(posedge clk);
    #1;
    store_start = 1'b0;
  endtask

  task automatic run_tile(input tile_cfg_t cfg, input int mode);
    int   cycles;
    logic seen;
    cycles = 0;
    seen   = 1'b0;
    start_tile(cfg, mode);
    while (!seen && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      seen   = store_fin;
      cycles = cycles + 1;
    end
    if (!seen) begin
      $display("store_fin did not arrive within %0d cycles, the tile never finished", cycles);
      tb_errors++;
    end
    // give the checker time to close the tile
    repeat (4) @(posedge clk);
  endtask

  task automatic report_test(input string name, input int errors_before);
    int errors_now;
    errors_now = checker_i.error_count + tb_errors;
    tests_run++;
    if (errors_now != errors_before) begin
      tests_failed++;
    end
    $display("test %0d %s: %s, %0d errors", tests_run, name,
             (errors_now == errors_before) ? "pass" : "fail", errors_now - errors_before);
  endtask

  initial begin
    int errors_before;
    int total;
    void'($urandom(32));
    reset          = 1'b1;
    store_start    = 1'b0;
    tile_cfg       = '0;
    ddr_cmd_ready  = 1'b1;
    ddr_data_ready = 1'b1;
    fifo_data      = '0;
    rds_seen       = '0;
    ready_mode     = 0;
    tb_errors      = 0;
    tests_run      = 0;
    tests_failed   = 0;
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;

    errors_before = checker_i.error_count + tb_errors;
    run_tile(make_cfg(mode_wide, 64, 2, 1, 1), 0);
    report_test("mode_wide tile", errors_before);

    errors_before = checker_i.error_count + tb_errors;
    run_tile(make_cfg(mode_int8, 40, 3, 2, 33), 0);
    report_test("mode_int8 pairing", errors_before);

    errors_before = checker_i.error_count + tb_errors;
    run_tile(make_cfg(mode_wide, 100, 3, 1, 1), 0);
    report_test("command splitting", errors_before);

    errors_before = checker_i.error_count + tb_errors;
    run_tile(make_cfg(mode_int8, 64, 3, 4, 1), 1);
    report_test("back-pressure", errors_before);

    // reset in the middle of a tile and two tiles back to back afterwards
    errors_before = checker_i.error_count + tb_errors;
    start_tile(make_cfg(mode_wide, 64, 3, 1, 1), 0);
    repeat (20) @(posedge clk);
    apply_reset();
    run_tile(make_cfg(mode_wide, 96, 2, 1, 17), 2);
    run_tile(make_cfg(mode_int8, 24, 2, 3, 9), 0);
    report_test("reset and spacing", errors_before);

    total = checker_i.error_count + tb_errors;
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total);
    if (total == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+hdl
hdl/conv_store_pkg.sv
hdl/store_cmd_gen.sv
hdl/fifo_drain_seq.sv
hdl/ddr_beat_assembler.sv
hdl/conv_store_top.sv
verification/conv_store_checker.sv
verification/conv_store_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the conv_store testbench with Verilator.
# Exits non-zero if the build fails, the simulation fails, or the log reports failure.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps \
  -f sources.f --top-module conv_store_tb \
  -Mdir obj_dir -o conv_store_sim > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/conv_store_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "ERRORS FOUND" "$SIM_LOG"; then
  exit 1
fi
exit 0
